// File: design/spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// Register offsets, byte addressed.
`define SPI_ADDR_DATA 3'h0
`define SPI_ADDR_CTRL 3'h4

// Reset values of the CTRL fields.
`define SPI_SELECTS_RESET 8'hff
`define SPI_CONF_RESET 8'h00
`define SPI_ITD_RESET 2'b00

// sclk half-period in clk cycles at speed 0.
// Each speed step doubles it.
`define SPI_DIV_BASE 2

`endif

// File: design/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // APB2 request, driven by the bus master.
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [2:0]  paddr;    // Byte address.
    logic [31:0] pwdata;
    logic [3:0]  pstrb;    // One strobe per byte lane.
  } apb_req_t;

  // Zero-wait response, so read data is all there is.
  typedef struct packed {
    logic [31:0] prdata;
  } apb_rsp_t;

  // Configuration byte, CTRL bits 23:16.
  typedef struct packed {
    logic [3:0] rsvd;
    logic [1:0] speed;     // Half-period select.
    logic       cpol;      // Idle level of sclk.
    logic       cpha;      // Set to sample on the trailing edge.
  } spi_conf_t;

  // Handshake between a DATA write, the shifter and the DATA read.
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    COMPLETE,
    RELEASE
  } xfer_state_e;

endpackage

`default_nettype wire

// File: design/spi_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_config.svh"

module spi_clk_div (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] speed,
  input  logic       busy,
  output logic       tick
);

  localparam logic [4:0] DIV_BASE = 5'(`SPI_DIV_BASE);

  logic [4:0] half_period;
  logic [4:0] reload;
  logic [4:0] cnt;

  // 2, 4, 8 or 16 clk cycles per half-period.
  assign half_period = DIV_BASE << speed;
  assign reload      = half_period - 5'd1;

  // Held at the full count while idle, so the first tick
  // always comes one whole half-period after start.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!busy) begin
      cnt <= reload;
    end else if (cnt == 5'd0) begin
      cnt <= reload;                 // Next half-period.
    end else begin
      cnt <= cnt - 5'd1;
    end
  end

  assign tick = busy && (cnt == 5'd0);

endmodule

`default_nettype wire

// File: design/spi_xcvr.sv
`timescale 1ns/1ps
`default_nettype none

module spi_xcvr (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_conf_t conf,
  input  logic               start,
  input  logic [7:0]         tx_byte,
  input  logic               tick,
  output logic               busy,
  output logic               done,
  output logic [7:0]         rx_byte,
  input  logic               miso,
  output logic               mosi,
  output logic               sclk
);

  logic [3:0] edge_cnt;      // sclk edges seen so far.
  logic       phase;         // Offset of sclk from its idle level.
  logic       odd_edge;
  logic       last_edge;
  logic       shift_en;
  logic       sample_en;
  logic [7:0] tx_sr;
  logic [7:0] rx_sr;
  logic       mosi_q;

  // Edges are numbered from one, so an even count means an odd edge.
  assign odd_edge  = ~edge_cnt[0];
  assign last_edge = (edge_cnt == 4'd15);

  // cpha 0 samples on leading edges, cpha 1 on trailing edges.
  assign shift_en  = tick && (conf.cpha ? odd_edge : ~odd_edge);
  assign sample_en = tick && (conf.cpha ? ~odd_edge : odd_edge);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      edge_cnt <= '0;
      phase    <= 1'b0;
      mosi_q   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        edge_cnt <= '0;
        phase    <= 1'b0;
        // MSB goes out ahead of the first edge.
        if (!conf.cpha) begin
          mosi_q <= tx_byte[7];
        end
      end else if (tick) begin
        phase    <= ~phase;
        edge_cnt <= edge_cnt + 4'd1;
        if (shift_en) begin
          mosi_q <= tx_sr[7];
        end
        if (last_edge) begin
          busy <= 1'b0;
          done <= 1'b1;              // One cycle after the sixteenth tick.
        end
      end
    end
  end

  // Data path shift registers.
  always_ff @(posedge clk) begin
    if (start) begin
      tx_sr <= conf.cpha ? tx_byte : {tx_byte[6:0], 1'b0};
    end else if (shift_en) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
    if (sample_en) begin
      rx_sr <= {rx_sr[6:0], miso};   // MSB arrives first.
    end
  end

  assign sclk    = conf.cpol ^ phase;
  assign mosi    = mosi_q;
  assign rx_byte = rx_sr;

  // Sixteen toggles bring sclk back to rest.
  assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> (sclk == conf.cpol))
    else $error("spi_xcvr: sclk not at cpol while idle");

  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy)
    else $error("spi_xcvr: start during a transfer");

endmodule

`default_nettype wire

// File: design/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_config.svh"

module spi_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::apb_req_t  apb_req,
  output spi_pkg::apb_rsp_t  apb_rsp,
  input  logic               wp_n,
  input  logic               touch,
  input  logic               done,
  input  logic [7:0]         rx_in,
  output logic               start,
  output logic [7:0]         tx_byte,
  output spi_pkg::spi_conf_t conf,
  output logic [7:0]         selects,
  output logic [1:0]         itd
);

  import spi_pkg::*;

  xfer_state_e state;
  xfer_state_e state_next;
  logic        access;
  logic        wr;
  logic        rd;
  logic        sel_data;
  logic        sel_ctrl;
  logic        tx_ready;
  logic        rx_ready;
  logic [7:0]  rx_byte;
  logic [31:0] ctrl_word;

  assign access   = apb_req.psel && apb_req.penable;   // Access phase.
  assign wr       = access && apb_req.pwrite;
  assign rd       = access && !apb_req.pwrite;
  assign sel_data = (apb_req.paddr == `SPI_ADDR_DATA);
  assign sel_ctrl = (apb_req.paddr == `SPI_ADDR_CTRL);

  // A DATA write outside IDLE is dropped.
  assign start   = wr && sel_data && apb_req.pstrb[0] && (state == IDLE);
  assign tx_byte = apb_req.pwdata[7:0];   // Loaded by the transceiver on start.

  // CTRL fields, one strobe per byte lane.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= `SPI_SELECTS_RESET;
      conf    <= `SPI_CONF_RESET;
      itd     <= `SPI_ITD_RESET;
    end else if (wr && sel_ctrl) begin
      if (apb_req.pstrb[3]) begin
        selects <= apb_req.pwdata[31:24];
      end
      if (apb_req.pstrb[2]) begin
        conf <= apb_req.pwdata[23:16];
      end
      if (apb_req.pstrb[1]) begin
        itd <= apb_req.pwdata[9:8];
      end
    end
  end

  // Received byte.
  always_ff @(posedge clk) begin
    if (done && (state == BUSY)) begin
      rx_byte <= rx_in;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:     if (start) state_next = BUSY;
      BUSY:     if (done) state_next = COMPLETE;
      COMPLETE: if (rd && sel_data) state_next = RELEASE;
      RELEASE:  if (!access) state_next = IDLE;   // Wait for the read to end.
      default:  state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign tx_ready = (state != BUSY);
  assign rx_ready = (state == COMPLETE);

  assign ctrl_word = {selects, conf, 6'b0, itd, 4'b0,
                      touch, ~wp_n, tx_ready, rx_ready};

  // Zero outside a read access phase.
  always_comb begin
    apb_rsp.prdata = '0;
    if (rd) begin
      if (sel_data) begin
        apb_rsp.prdata = {24'b0, rx_byte};
      end else if (sel_ctrl) begin
        apb_rsp.prdata = ctrl_word;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (state == IDLE) ##1 (state == BUSY))
    else $error("spi_regs: start outside IDLE");

  // The transceiver only finishes what this block started.
  assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (state == BUSY))
    else $error("spi_regs: done with no transfer pending");

endmodule

`default_nettype wire

// File: design/spi_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_top (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::apb_req_t apb_req,
  output spi_pkg::apb_rsp_t apb_rsp,
  input  logic              miso,
  output logic              mosi,
  output logic              sclk,
  output logic [7:0]        selects,
  output logic [1:0]        itd,
  input  logic              wp_n,
  input  logic              touch
);

  import spi_pkg::*;

  spi_conf_t  conf;
  logic       start;
  logic       done;
  logic       busy;
  logic       tick;
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;

  spi_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wp_n    (wp_n),
    .touch   (touch),
    .done    (done),
    .rx_in   (rx_byte),
    .start   (start),
    .tx_byte (tx_byte),
    .conf    (conf),
    .selects (selects),
    .itd     (itd)
  );

  spi_clk_div u_clk_div (
    .clk   (clk),
    .rst_n (rst_n),
    .speed (conf.speed),
    .busy  (busy),
    .tick  (tick)
  );

  spi_xcvr u_xcvr (
    .clk     (clk),
    .rst_n   (rst_n),
    .conf    (conf),
    .start   (start),
    .tx_byte (tx_byte),
    .tick    (tick),
    .busy    (busy),
    .done    (done),
    .rx_byte (rx_byte),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk)
  );

endmodule

`default_nettype wire

// File: verification/spi_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_config.svh"

module spi_ctrl_tb;

  import spi_pkg::*;

  typedef struct packed {
    logic [7:0] tx;
    logic [1:0] speed;
    logic       cpol;
    logic       cpha;
    logic [7:0] reply;       // Byte the slave sends back.
  } entry_t;

  localparam int N_ENTRIES = 8;
  // One byte at the slowest speed, plus the done and state latency.
  localparam int BYTE_CYCLES = 16 * (`SPI_DIV_BASE << 3) + 4;
  localparam int TIMEOUT_CYCLES = (N_ENTRIES + 1) * (BYTE_CYCLES + 40) + 10 + 200;

  logic       clk;
  logic       rst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  logic       miso;
  logic       mosi;
  logic       sclk;
  logic [7:0] selects;
  logic [1:0] itd;
  logic       wp_n;
  logic       touch;

  entry_t     stim [N_ENTRIES];
  entry_t     busy_case;
  logic [7:0] cur_conf;
  logic [7:0] slave_rx;
  int         sclk_edges = 0;
  int         checks = 0;
  int         errors = 0;

  spi_ctrl_top u_spi_ctrl_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .miso    (miso),
    .mosi    (mosi),
    .sclk    (sclk),
    .selects (selects),
    .itd     (itd),
    .wp_n    (wp_n),
    .touch   (touch)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(sclk) sclk_edges = sclk_edges + 1;

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] expected_ctrl(input logic [7:0] sel, input logic [7:0] cf,
                                                input logic [1:0] itd_v, input logic txr,
                                                input logic rxr);
    return {sel, cf, 6'b0, itd_v, 4'b0, touch, ~wp_n, txr, rxr};
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
    end
  endtask

  task automatic write_apb(input logic [2:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    apb_req.pstrb   = strb;
    @(negedge clk);
    apb_req.penable = 1'b1;         // Access phase.
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic read_apb(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pstrb   = 4'h0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1 data = apb_rsp.prdata;       // Well clear of both clock edges.
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  // Slave side of one byte, MSB first in both directions.
  task automatic slave_xfer(input logic [7:0] reply, input logic cpha);
    logic [7:0] sh;
    logic [7:0] cap;
    sh  = reply;
    cap = 8'h00;
    if (!cpha) begin
      miso = sh[7];                 // First bit ahead of the first edge.
      sh   = {sh[6:0], 1'b0};
    end
    for (int e = 1; e <= 16; e++) begin
      @(sclk);
      if (e[0] ^ cpha) begin
        cap = {cap[6:0], mosi};
      end else begin
        miso = sh[7];
        sh   = {sh[6:0], 1'b0};
      end
    end
    slave_rx = cap;
  endtask

  task automatic run_transfer(input entry_t e, input logic busy_write);
    logic [31:0] rd;
    int          edges0;
    cur_conf = {4'h0, e.speed, e.cpol, e.cpha};
    write_apb(`SPI_ADDR_CTRL, {8'h00, cur_conf, 16'h0000}, 4'b0100);
    check(32'(sclk), 32'(e.cpol), "sclk at rest before transfer");
    edges0 = sclk_edges;
    fork
      slave_xfer(e.reply, e.cpha);
    join_none
    write_apb(`SPI_ADDR_DATA, {24'h0, e.tx}, 4'b0001);
    if (busy_write) begin
      write_apb(`SPI_ADDR_DATA, {24'h0, ~e.tx}, 4'b0001);   // Must be dropped.
    end
    read_apb(`SPI_ADDR_CTRL, rd);
    check(32'(rd[1]), 32'd0, "tx_ready low during transfer");
    while (!rd[0]) begin
      read_apb(`SPI_ADDR_CTRL, rd);
    end
    check(32'(rd[1]), 32'd1, "tx_ready high once complete");
    read_apb(`SPI_ADDR_DATA, rd);
    check(rd, {24'h0, e.reply}, "DATA read returns slave reply");
    check(32'(slave_rx), 32'(e.tx), "slave captured tx byte");
    read_apb(`SPI_ADDR_CTRL, rd);
    check(32'(rd[1:0]), 32'b10, "ready flags after DATA read");
    check(32'(sclk), 32'(e.cpol), "sclk at rest after transfer");
    check(32'(sclk_edges - edges0), 32'd16, "sclk edges in one byte");
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] lfsr;
    rst_n   = 1'b0;
    apb_req = '0;
    miso    = 1'b0;
    wp_n    = 1'b0;
    touch   = 1'b0;
    stim = '{
      '{8'ha5, 2'd0, 1'b0, 1'b0, 8'h3c},
      '{8'h5a, 2'd1, 1'b0, 1'b1, 8'hc3},
      '{8'h81, 2'd2, 1'b1, 1'b0, 8'h7e},
      '{8'h0f, 2'd3, 1'b1, 1'b1, 8'hf0},
      '{8'h96, 2'd3, 1'b0, 1'b0, 8'h00},
      '{8'h69, 2'd2, 1'b0, 1'b1, 8'h00},
      '{8'he7, 2'd1, 1'b1, 1'b0, 8'h00},
      '{8'h18, 2'd0, 1'b1, 1'b1, 8'h00}
    };
    // Last four replies are pseudo random.
    lfsr = 32'hc65;
    for (int i = 4; i < N_ENTRIES; i++) begin
      for (int b = 0; b < 8; b++) begin
        lfsr = lfsr_next(lfsr);
        stim[i].reply = {stim[i].reply[6:0], lfsr[0]};
      end
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_apb(`SPI_ADDR_CTRL, rd);
    check(rd, expected_ctrl(8'hff, 8'h00, 2'b00, 1'b1, 1'b0), "CTRL after reset");
    check(32'(sclk), 32'd0, "sclk after reset");
    @(negedge clk);
    wp_n  = 1'b1;
    touch = 1'b1;
    read_apb(`SPI_ADDR_CTRL, rd);
    check(rd, expected_ctrl(8'hff, 8'h00, 2'b00, 1'b1, 1'b0), "CTRL board inputs");

    for (int i = 0; i < N_ENTRIES; i++) begin
      run_transfer(stim[i], 1'b0);
    end
    busy_case = '{8'h3b, 2'd1, 1'b1, 1'b1, 8'hd4};
    run_transfer(busy_case, 1'b1);

    // Byte strobes on CTRL.
    write_apb(`SPI_ADDR_CTRL, 32'h5aff_0300, 4'b1000);
    check(32'(selects), 32'h5a, "selects after strobed write");
    check(32'(itd), 32'd0, "itd kept by selects write");
    write_apb(`SPI_ADDR_CTRL, 32'h0000_0200, 4'b0010);
    check(32'(selects), 32'h5a, "selects kept by itd write");
    check(32'(itd), 32'b10, "itd after strobed write");
    read_apb(`SPI_ADDR_CTRL, rd);
    check(rd, expected_ctrl(8'h5a, cur_conf, 2'b10, 1'b1, 1'b0), "CTRL after strobed writes");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/spi_pkg.sv
design/spi_clk_div.sv
design/spi_xcvr.sv
design/spi_regs.sv
design/spi_ctrl_top.sv
verification/spi_ctrl_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spi_ctrl_tb -f sources.f

# The simulation status alone is not trusted; the pass line decides.
out=$(./obj_dir/Vspi_ctrl_tb || true)
echo "$out"
echo "$out" | grep -qx "Finished with no errors"
echo "Simulation passed"
